// ==== source/axi_remap_pkg.sv ====
/*
  AXI remap subsystem package
  Widths, reduced AXI4 channel and bundle types, response codes
  and the address window rule used by the translation table
*/
`default_nettype none

package axi_remap_pkg;

  // bus geometry
  localparam int ADDR_WIDTH = 16;
  localparam int DATA_WIDTH = 32;
  localparam int ID_WIDTH   = 2;
  localparam int STRB_WIDTH = DATA_WIDTH / 8;

  // byte lanes inside one word
  localparam int BYTE_OFF_WIDTH = $clog2(STRB_WIDTH);

  // translation table
  localparam int NUM_RULES      = 4;
  localparam int RULE_IDX_WIDTH = $clog2(NUM_RULES);

  // memory behind the master port
  localparam int MEM_WORDS     = 256;
  localparam int MEM_IDX_WIDTH = $clog2(MEM_WORDS);

  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [ID_WIDTH-1:0]   id_t;
  typedef logic [STRB_WIDTH-1:0] strb_t;
  typedef logic [7:0]            len_t;
  typedef logic [1:0]            burst_t;
  typedef logic [1:0]            resp_t;

  localparam burst_t BURST_FIXED = 2'b00;
  localparam burst_t BURST_INCR  = 2'b01;

  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  // address channels share one layout
  typedef struct packed {
    id_t    id;
    addr_t  addr;
    len_t   len;
    burst_t burst;
  } aw_chan_t;

  typedef struct packed {
    id_t    id;
    addr_t  addr;
    len_t   len;
    burst_t burst;
  } ar_chan_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } w_chan_t;

  typedef struct packed {
    id_t   id;
    resp_t resp;
  } b_chan_t;

  typedef struct packed {
    id_t   id;
    data_t data;
    resp_t resp;
    logic  last;
  } r_chan_t;

  typedef struct packed {
    aw_chan_t aw;
    logic     aw_valid;
    w_chan_t  w;
    logic     w_valid;
    logic     b_ready;
    ar_chan_t ar;
    logic     ar_valid;
    logic     r_ready;
  } axi_req_t;

  typedef struct packed {
    logic    aw_ready;
    logic    w_ready;
    b_chan_t b;
    logic    b_valid;
    logic    ar_ready;
    r_chan_t r;
    logic    r_valid;
  } axi_resp_t;

  // one translation window
  typedef struct packed {
    logic  enable;
    addr_t base;
    addr_t mask;
    addr_t target;
  } remap_rule_t;

endpackage

`default_nettype wire

// ==== source/axi_addr_remap.sv ====
/*
  Address remap table
  Holds four translation windows written through a config strobe
  and maps the write and read addresses combinationally. The first
  enabled window that matches wins and unmatched addresses pass through.
*/
`timescale 1ns/1ps
`default_nettype none

module axi_addr_remap
  import axi_remap_pkg::*;
(
  input  wire                      clk_i,
  input  wire                      reset_i,
  // configuration port
  input  wire                      cfg_we_i,
  input  wire [RULE_IDX_WIDTH-1:0] cfg_idx_i,
  input  remap_rule_t              cfg_rule_i,
  // addresses to translate
  input  addr_t                    aw_addr_i,
  input  addr_t                    ar_addr_i,
  output addr_t                    aw_addr_o,
  output addr_t                    ar_addr_o
);

  remap_rule_t [NUM_RULES-1:0] rules_q;

  // priority match, lowest index checked first
  function automatic addr_t translate(
    input addr_t                       addr,
    input remap_rule_t [NUM_RULES-1:0] rules
  );
    addr_t result;
    logic  hit;
    result = addr;
    hit    = 1'b0;
    for (int i = 0; i < NUM_RULES; i++) begin
      if (!hit && rules[i].enable && ((addr & rules[i].mask) == rules[i].base)) begin
        // keep the offset bits below the window and add them to the target
        result = rules[i].target + (addr & ~rules[i].mask);
        hit    = 1'b1;
      end
    end
    return result;
  endfunction

  // table update, visible to addresses on the following cycle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rules_q <= '0;
    end else if (cfg_we_i) begin
      rules_q[cfg_idx_i] <= cfg_rule_i;
    end
  end

  // both channels look up the same table
  always_comb begin
    aw_addr_o = translate(aw_addr_i, rules_q);
    ar_addr_o = translate(ar_addr_i, rules_q);
  end

endmodule

`default_nettype wire

// ==== source/axi_modify_address.sv ====
/*
  AXI address substitution
  Exports the incoming AW and AR addresses and forwards the request
  with the externally supplied addresses in their place. All other
  request fields and the whole response go through untouched.
*/
`timescale 1ns/1ps
`default_nettype none

module axi_modify_address
  import axi_remap_pkg::*;
(
  // slave port
  input  axi_req_t  slv_req_i,
  output axi_resp_t slv_resp_o,
  output addr_t     slv_aw_addr_o,
  output addr_t     slv_ar_addr_o,
  // master port
  output axi_req_t  mst_req_o,
  input  axi_resp_t mst_resp_i,
  input  addr_t     mst_aw_addr_i,
  input  addr_t     mst_ar_addr_i
);

  // addresses handed out for translation
  assign slv_aw_addr_o = slv_req_i.aw.addr;
  assign slv_ar_addr_o = slv_req_i.ar.addr;

  // request rebuilt with only the two addresses replaced
  assign mst_req_o = '{
    aw: '{
      id:    slv_req_i.aw.id,
      addr:  mst_aw_addr_i,
      len:   slv_req_i.aw.len,
      burst: slv_req_i.aw.burst
    },
    aw_valid: slv_req_i.aw_valid,
    w:        slv_req_i.w,
    w_valid:  slv_req_i.w_valid,
    b_ready:  slv_req_i.b_ready,
    ar: '{
      id:    slv_req_i.ar.id,
      addr:  mst_ar_addr_i,
      len:   slv_req_i.ar.len,
      burst: slv_req_i.ar.burst
    },
    ar_valid: slv_req_i.ar_valid,
    r_ready:  slv_req_i.r_ready
  };

  // handshakes and responses are not affected by translation
  assign slv_resp_o = mst_resp_i;

endmodule

`default_nettype wire

// ==== source/axi_sram_slave.sv ====
/*
  AXI memory slave
  Word-wide 256-entry memory serving one burst at a time.
  Supports INCR and FIXED bursts (WRAP runs as INCR), byte strobes
  on writes and SLVERR for beats beyond the end of the memory.
*/
`timescale 1ns/1ps
`default_nettype none

module axi_sram_slave
  import axi_remap_pkg::*;
(
  input  wire       clk_i,
  input  wire       reset_i,
  input  axi_req_t  req_i,
  output axi_resp_t resp_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WDATA,
    ST_WRESP,
    ST_RDATA
  } state_e;

  state_e state_q;

  // burst context captured at the address handshake
  id_t    id_q;
  addr_t  addr_q;
  len_t   beats_q;
  burst_t burst_q;
  logic   err_q;

  data_t mem_q [MEM_WORDS];

  logic aw_ready;
  logic ar_ready;
  logic w_ready;
  logic b_valid;
  logic r_valid;
  logic r_last;

  logic aw_hs;
  logic ar_hs;
  logic w_hs;
  logic b_hs;
  logic r_hs;

  logic                     beat_oor;
  logic [MEM_IDX_WIDTH-1:0] word_idx;
  addr_t                    addr_next;
  data_t                    rd_data;

  assign aw_ready = (state_q == ST_IDLE);
  // AW wins when both address channels are valid
  assign ar_ready = (state_q == ST_IDLE) && !req_i.aw_valid;
  assign w_ready  = (state_q == ST_WDATA);
  assign b_valid  = (state_q == ST_WRESP);
  assign r_valid  = (state_q == ST_RDATA);

  assign aw_hs = req_i.aw_valid && aw_ready;
  assign ar_hs = req_i.ar_valid && ar_ready;
  assign w_hs  = req_i.w_valid && w_ready;
  assign b_hs  = req_i.b_ready && b_valid;
  assign r_hs  = req_i.r_ready && r_valid;

  // anything above the top word index is outside the memory
  assign beat_oor  = |addr_q[ADDR_WIDTH-1:MEM_IDX_WIDTH+BYTE_OFF_WIDTH];
  assign word_idx  = addr_q[MEM_IDX_WIDTH+BYTE_OFF_WIDTH-1:BYTE_OFF_WIDTH];
  assign addr_next = (burst_q == BURST_FIXED) ? addr_q : addr_q + addr_t'(STRB_WIDTH);

  assign r_last  = (beats_q == '0);
  assign rd_data = beat_oor ? '0 : mem_q[word_idx];

  // transaction sequencing
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (aw_hs) begin
            state_q <= ST_WDATA;
          end else if (ar_hs) begin
            state_q <= ST_RDATA;
          end
        end
        ST_WDATA: begin
          if (w_hs && req_i.w.last) begin
            state_q <= ST_WRESP;
          end
        end
        ST_WRESP: begin
          if (b_hs) begin
            state_q <= ST_IDLE;
          end
        end
        ST_RDATA: begin
          if (r_hs && r_last) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // burst context and beat address counter
  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      id_q    <= req_i.aw.id;
      addr_q  <= req_i.aw.addr;
      beats_q <= req_i.aw.len;
      burst_q <= req_i.aw.burst;
      err_q   <= 1'b0;
    end else if (ar_hs) begin
      id_q    <= req_i.ar.id;
      addr_q  <= req_i.ar.addr;
      beats_q <= req_i.ar.len;
      burst_q <= req_i.ar.burst;
    end else if (w_hs) begin
      addr_q <= addr_next;
      // one bad beat turns the whole write response into SLVERR
      err_q  <= err_q | beat_oor;
    end else if (r_hs) begin
      addr_q  <= addr_next;
      beats_q <= beats_q - 1'b1;
    end
  end

  // byte-lane writes, beats outside the memory are dropped
  always_ff @(posedge clk_i) begin
    if (w_hs && !beat_oor) begin
      for (int b = 0; b < STRB_WIDTH; b++) begin
        if (req_i.w.strb[b]) begin
          mem_q[word_idx][8*b +: 8] <= req_i.w.data[8*b +: 8];
        end
      end
    end
  end

  assign resp_o = '{
    aw_ready: aw_ready,
    w_ready:  w_ready,
    b: '{
      id:   id_q,
      resp: err_q ? RESP_SLVERR : RESP_OKAY
    },
    b_valid:  b_valid,
    ar_ready: ar_ready,
    r: '{
      id:   id_q,
      data: rd_data,
      resp: beat_oor ? RESP_SLVERR : RESP_OKAY,
      last: r_last
    },
    r_valid:  r_valid
  };

endmodule

`default_nettype wire

// ==== source/axi_remap_top.sv ====
/*
  AXI remap subsystem top
  Address substitution stage and remap table in front of the
  on-chip memory slave
*/
`timescale 1ns/1ps
`default_nettype none

module axi_remap_top
  import axi_remap_pkg::*;
(
  input  wire                      clk_i,
  input  wire                      reset_i,
  input  axi_req_t                 slv_req_i,
  output axi_resp_t                slv_resp_o,
  input  wire                      cfg_we_i,
  input  wire [RULE_IDX_WIDTH-1:0] cfg_idx_i,
  input  remap_rule_t              cfg_rule_i
);

  addr_t     aw_addr_in;
  addr_t     ar_addr_in;
  addr_t     aw_addr_out;
  addr_t     ar_addr_out;
  axi_req_t  mem_req;
  axi_resp_t mem_resp;

  axi_modify_address u_modify (
    .slv_req_i     (slv_req_i),
    .slv_resp_o    (slv_resp_o),
    .slv_aw_addr_o (aw_addr_in),
    .slv_ar_addr_o (ar_addr_in),
    .mst_req_o     (mem_req),
    .mst_resp_i    (mem_resp),
    .mst_aw_addr_i (aw_addr_out),
    .mst_ar_addr_i (ar_addr_out)
  );

  axi_addr_remap u_remap (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .cfg_we_i   (cfg_we_i),
    .cfg_idx_i  (cfg_idx_i),
    .cfg_rule_i (cfg_rule_i),
    .aw_addr_i  (aw_addr_in),
    .ar_addr_i  (ar_addr_in),
    .aw_addr_o  (aw_addr_out),
    .ar_addr_o  (ar_addr_out)
  );

  axi_sram_slave u_sram (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .req_i   (mem_req),
    .resp_o  (mem_resp)
  );

endmodule

`default_nettype wire

// ==== test/axi_remap_props.sv ====
/*
  Protocol properties for the AXI memory slave
  Response stability under back-pressure, R-last framing
  and write response ordering
*/
`timescale 1ns/1ps
`default_nettype none

module axi_remap_props
  import axi_remap_pkg::*;
(
  input wire       clk_i,
  input wire       reset_i,
  input axi_req_t  req_i,
  input axi_resp_t resp_i
);

  len_t ar_len_q;
  len_t r_count_q;
  logic w_done_q;

  // beat position inside the current read and write progress
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ar_len_q  <= '0;
      r_count_q <= '0;
      w_done_q  <= 1'b0;
    end else begin
      if (req_i.ar_valid && resp_i.ar_ready) begin
        ar_len_q  <= req_i.ar.len;
        r_count_q <= '0;
      end else if (resp_i.r_valid && req_i.r_ready) begin
        r_count_q <= r_count_q + 8'd1;
      end
      if (req_i.aw_valid && resp_i.aw_ready) begin
        w_done_q <= 1'b0;
      end else if (req_i.w_valid && resp_i.w_ready && req_i.w.last) begin
        w_done_q <= 1'b1;
      end
    end
  end

  r_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    resp_i.r_valid && !req_i.r_ready |=> resp_i.r_valid && $stable(resp_i.r))
    else $error("read beat changed or dropped while stalled");

  b_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    resp_i.b_valid && !req_i.b_ready |=> resp_i.b_valid && $stable(resp_i.b))
    else $error("write response changed or dropped while stalled");

  r_last_on_len: assert property (@(posedge clk_i) disable iff (reset_i)
    resp_i.r_valid |-> (resp_i.r.last == (r_count_q == ar_len_q)))
    else $error("r_last not on the final beat of the burst");

  b_after_last: assert property (@(posedge clk_i) disable iff (reset_i)
    resp_i.b_valid |-> w_done_q)
    else $error("write response before the last write beat");

endmodule

bind axi_sram_slave axi_remap_props u_props (
  .clk_i   (clk_i),
  .reset_i (reset_i),
  .req_i   (req_i),
  .resp_i  (resp_o)
);

`default_nettype wire

// ==== test/tb_axi_remap.sv ====
/*
  Testbench for the AXI remap subsystem
  Sends write and read bursts through the remap table into the memory
  slave and checks every response against a memory and rule model
*/
`timescale 1ns/1ps
`default_nettype none

module tb_axi_remap
  import axi_remap_pkg::*;
();

  localparam int NUM_RANDOM = 20;
  localparam int MAX_BEATS  = 8;
  localparam int MEM_BYTES  = MEM_WORDS * STRB_WIDTH;
  // ten cycles per beat of all tests plus setup margin
  localparam int CYCLE_LIMIT = 10 * (MEM_WORDS + 4 * NUM_RANDOM * MAX_BEATS + 64) + 200;

  logic                      clk = 1'b0;
  logic                      reset;
  axi_req_t                  req;
  axi_resp_t                 resp;
  logic                      cfg_we;
  logic [RULE_IDX_WIDTH-1:0] cfg_idx;
  remap_rule_t               cfg_rule;

  // reference model state
  data_t       model_mem [MEM_WORDS];
  remap_rule_t model_rules [NUM_RULES];
  r_chan_t     exp_r [$];

  logic [15:0] lfsr_q;
  logic        stall_en;
  int          cycles = 0;
  int          checks;
  int          errors;
  int          test_errors;

  axi_remap_top UUT (
    .clk_i      (clk),
    .reset_i    (reset),
    .slv_req_i  (req),
    .slv_resp_o (resp),
    .cfg_we_i   (cfg_we),
    .cfg_idx_i  (cfg_idx),
    .cfg_rule_i (cfg_rule)
  );

  initial begin
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout, tests did not finish within %0d cycles", CYCLE_LIMIT);
      $display("TEST FAILED");
      $finish;
    end
  end

  // galois lfsr stepped once per bit drawn
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // scan from the top so the lowest matching window is applied last
  function automatic addr_t model_translate(input addr_t a);
    addr_t mapped;
    mapped = a;
    for (int i = NUM_RULES - 1; i >= 0; i--) begin
      if (model_rules[i].enable && ((a & model_rules[i].mask) == model_rules[i].base)) begin
        mapped = model_rules[i].target + (a & ~model_rules[i].mask);
      end
    end
    return mapped;
  endfunction

  function automatic addr_t beat_addr(input addr_t base, input burst_t burst, input int beat);
    if (burst == BURST_FIXED) begin
      return base;
    end
    return base + addr_t'(beat * STRB_WIDTH);
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  task automatic report_test(input string name);
    $display("%-14s %s, %0d errors", name, (errors == test_errors) ? "pass" : "fail",
             errors - test_errors);
    test_errors = errors;
  endtask

  // new rule is live for addresses on the next cycle
  task automatic program_rule(input int idx, input remap_rule_t rule);
    cfg_we   = 1'b1;
    cfg_idx  = idx[RULE_IDX_WIDTH-1:0];
    cfg_rule = rule;
    @(negedge clk);
    cfg_we = 1'b0;
    model_rules[idx] = rule;
  endtask

  // patterned bursts write full words derived from the beat address
  task automatic write_burst(input id_t id, input addr_t addr, input len_t len,
                             input burst_t burst, input logic patterned);
    addr_t base;
    addr_t baddr;
    data_t data;
    strb_t strb;
    logic  hs;
    logic  err;
    base = model_translate(addr);
    err  = 1'b0;
    req.aw = '{id: id, addr: addr, len: len, burst: burst};
    req.aw_valid = 1'b1;
    do begin
      #1;
      hs = resp.aw_ready;
      @(negedge clk);
    end while (!hs);
    req.aw_valid = 1'b0;
    for (int beat = 0; beat <= int'(len); beat++) begin
      baddr = beat_addr(base, burst, beat);
      data  = patterned ? {~baddr, baddr} : rand_bits(32);
      strb  = patterned ? '1 : strb_t'(rand_bits(STRB_WIDTH));
      req.w = '{data: data, strb: strb, last: (beat == int'(len))};
      req.w_valid = 1'b0;
      do begin
        req.w_valid = req.w_valid || !(stall_en && (rand_bits(2) == 0));
        #1;
        hs = req.w_valid && resp.w_ready;
        @(negedge clk);
      end while (!hs);
      if (int'(baddr) >= MEM_BYTES) begin
        err = 1'b1;
      end else begin
        for (int b = 0; b < STRB_WIDTH; b++) begin
          if (strb[b]) begin
            model_mem[baddr[MEM_IDX_WIDTH+1:2]][8*b +: 8] = data[8*b +: 8];
          end
        end
      end
    end
    req.w_valid = 1'b0;
    do begin
      req.b_ready = !(stall_en && (rand_bits(2) == 0));
      #1;
      hs = req.b_ready && resp.b_valid;
      if (hs) begin
        check_value("b.id", 32'(resp.b.id), 32'(id));
        check_value("b.resp", 32'(resp.b.resp), 32'(err ? RESP_SLVERR : RESP_OKAY));
      end
      @(negedge clk);
    end while (!hs);
    req.b_ready = 1'b0;
  endtask

  task automatic read_burst(input id_t id, input addr_t addr, input len_t len,
                            input burst_t burst);
    addr_t   base;
    addr_t   baddr;
    r_chan_t exp;
    logic    hs;
    base = model_translate(addr);
    for (int i = 0; i <= int'(len); i++) begin
      baddr     = beat_addr(base, burst, i);
      exp.id    = id;
      exp.last  = (i == int'(len));
      exp.resp  = (int'(baddr) >= MEM_BYTES) ? RESP_SLVERR : RESP_OKAY;
      exp.data  = model_mem[baddr[MEM_IDX_WIDTH+1:2]];
      exp_r.push_back(exp);
    end
    req.ar = '{id: id, addr: addr, len: len, burst: burst};
    req.ar_valid = 1'b1;
    do begin
      #1;
      hs = resp.ar_ready;
      @(negedge clk);
    end while (!hs);
    req.ar_valid = 1'b0;
    while (exp_r.size() > 0) begin
      req.r_ready = !(stall_en && (rand_bits(2) == 0));
      #1;
      if (req.r_ready && resp.r_valid) begin
        exp = exp_r.pop_front();
        check_value("r.id", 32'(resp.r.id), 32'(exp.id));
        check_value("r.resp", 32'(resp.r.resp), 32'(exp.resp));
        check_value("r.last", 32'(resp.r.last), 32'(exp.last));
        if (exp.resp == RESP_OKAY) begin
          check_value("r.data", resp.r.data, exp.data);
        end
      end
      @(negedge clk);
    end
    req.r_ready = 1'b0;
    #1;
    assert (!resp.r_valid) else begin
      $display("read burst returned more beats than its length");
      errors++;
    end
    @(negedge clk);
  endtask

  task automatic random_pair();
    id_t    id;
    addr_t  addr;
    len_t   len;
    burst_t burst;
    int     r;
    id    = id_t'(rand_bits(ID_WIDTH));
    len   = len_t'(rand_bits(3));
    burst = rand_bits(1) ? BURST_FIXED : BURST_INCR;
    if (rand_bits(1)) begin
      r    = int'(rand_bits(RULE_IDX_WIDTH));
      addr = model_rules[r].base | (addr_t'(rand_bits(16)) & ~model_rules[r].mask);
    end else begin
      addr = addr_t'(rand_bits(10));
    end
    addr = addr & ~addr_t'(STRB_WIDTH - 1);
    write_burst(id, addr, len, burst, 1'b0);
    read_burst(id, addr, len, burst);
  endtask

  initial begin
    remap_rule_t rule;
    lfsr_q      = 16'd91;
    req         = '0;
    cfg_we      = 1'b0;
    cfg_idx     = '0;
    cfg_rule    = '0;
    stall_en    = 1'b0;
    checks      = 0;
    errors      = 0;
    test_errors = 0;
    for (int i = 0; i < NUM_RULES; i++) begin
      model_rules[i] = '0;
    end
    reset = 1'b1;
    repeat (2) @(negedge clk);
    reset = 1'b0;

    #1;
    check_value("w_ready", 32'(resp.w_ready), 32'd0);
    check_value("b_valid", 32'(resp.b_valid), 32'd0);
    check_value("r_valid", 32'(resp.r_valid), 32'd0);
    check_value("aw_ready", 32'(resp.aw_ready), 32'd1);
    check_value("ar_ready", 32'(resp.ar_ready), 32'd1);
    @(negedge clk);
    report_test("reset");

    // whole memory gets a known pattern first
    for (int a = 0; a < MEM_BYTES; a += 32) begin
      write_burst(id_t'(0), addr_t'(a), len_t'(7), BURST_INCR, 1'b1);
    end
    write_burst(id_t'(1), 16'h0040, len_t'(3), BURST_INCR, 1'b0);
    read_burst(id_t'(1), 16'h0040, len_t'(3), BURST_INCR);
    report_test("passthrough");

    rule = '{enable: 1'b1, base: 16'h8000, mask: 16'hFF00, target: 16'h0200};
    program_rule(0, rule);
    write_burst(id_t'(2), 16'h8010, len_t'(1), BURST_INCR, 1'b0);
    read_burst(id_t'(3), 16'h0210, len_t'(1), BURST_INCR);
    report_test("single rule");

    for (int i = 0; i < NUM_RULES; i++) begin
      rule.enable = 1'b1;
      rule.mask   = 16'hFFFF << (6 + int'(rand_bits(2)));
      rule.base   = {4'(i + 1), 12'(rand_bits(12))} & rule.mask;
      rule.target = addr_t'(rand_bits(10)) & rule.mask;
      program_rule(i, rule);
    end
    repeat (NUM_RANDOM) random_pair();
    report_test("random");

    stall_en = 1'b1;
    repeat (NUM_RANDOM) random_pair();
    stall_en = 1'b0;
    report_test("backpressure");

    // upper half of this burst lands past the end of the memory
    rule = '{enable: 1'b1, base: 16'h9000, mask: 16'hFF00, target: 16'h03F0};
    program_rule(0, rule);
    write_burst(id_t'(1), 16'h9000, len_t'(7), BURST_INCR, 1'b0);
    read_burst(id_t'(1), 16'h9000, len_t'(7), BURST_INCR);
    read_burst(id_t'(2), 16'h0000, len_t'(3), BURST_INCR);
    report_test("out of range");

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
source/axi_remap_pkg.sv
source/axi_addr_remap.sv
source/axi_modify_address.sv
source/axi_sram_slave.sv
source/axi_remap_top.sv
test/axi_remap_props.sv
test/tb_axi_remap.sv

// ==== Makefile ====
# Verilator build and run for the AXI remap subsystem

VERILATOR ?= verilator
TOP       ?= tb_axi_remap
RTL_TOP   ?= axi_remap_top
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  ?= TEST OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# pass only when the simulation prints the pass message
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) source/axi_remap_pkg.sv \
		source/axi_addr_remap.sv source/axi_modify_address.sv \
		source/axi_sram_slave.sv source/axi_remap_top.sv

clean:
	rm -rf $(BUILD_DIR)
